//--- sim.f
+incdir+hw
hw/fwd_gen_pkg.sv
hw/fwd_sync_fifo.sv
hw/fwd_config_ctrl.sv
hw/fwd_rebase.sv
hw/fwd_data_generator.sv
test/fwd_gen_asserts.sv
test/fwd_gen_checker.sv
test/fwd_gen_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the forward generator testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f sim.f --top-module fwd_gen_tb -o fwd_gen_sim \
    && ./obj_dir/fwd_gen_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0

//--- test/fwd_gen_tb.sv
// Forward generator testbench

`timescale 1ns/10ps
`include "fwd_gen_config.svh"

module fwd_gen_tb
    import fwd_gen_pkg::*;
();

    logic                 ap_clk = 1'b0;
    logic                 areset_generator;
    logic                 start;
    logic                 cfg_ack = 1'b0;
    logic [`FWD_ID_W-1:0] cfg_forward_value = '0;
    mem_packet_t          in_packet;
    logic                 in_valid;
    logic                 in_ready;
    mem_packet_t          out_packet;
    logic                 out_valid;
    logic                 out_ready;
    logic                 cfg_req;
    logic                 busy;
    logic                 final_check;
    int                   error_count;
    int                   check_count;
    int                   outstanding;
    int                   timeout_count = 0;
    logic [31:0]          rng = 32'h3d5b;
    logic [31:0]          resp_rng = 32'h3d5b;
    int                   ack_delay = 3;

    always #10 ap_clk = ~ap_clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    fwd_data_generator i_dut (.*);

    fwd_gen_checker i_checker (.*);

    // ----------------------------------------------------------
    // Config source, answers after a random delay
    // ----------------------------------------------------------
    always @(posedge ap_clk) begin
        #2;
        if (cfg_req && !cfg_ack) begin
            if (ack_delay == 0) begin
                resp_rng = xorshift32(resp_rng);
                cfg_forward_value = `FWD_ID_W'(1 + resp_rng % 40);
                cfg_ack = 1'b1;
            end else begin
                ack_delay--;
            end
        end else if (!cfg_req && cfg_ack) begin
            resp_rng = xorshift32(resp_rng);
            ack_delay = int'(resp_rng % 8);
            cfg_ack = 1'b0;
        end
    end

    // One cycle of random traffic on both ports
    task automatic drive_cycle(input int valid_pct, input int ready_pct);
        @(posedge ap_clk);
        #2;
        rng = xorshift32(rng);
        in_valid = (rng % 100) < valid_pct;
        rng = xorshift32(rng);
        out_ready = (rng % 100) < ready_pct;
        rng = xorshift32(rng);
        in_packet.from_id = `FWD_ID_W'(rng[5:0]);
        in_packet.to_id   = `FWD_ID_W'(rng[13:8]);
        rng = xorshift32(rng);
        in_packet.data = rng;
    endtask

    task automatic wait_for_busy;
        int cycles;
        cycles = 0;
        while (!busy && cycles < 100) begin
            @(posedge ap_clk);
            #2;
            cycles++;
        end
        if (!busy) begin
            $display("Timeout: busy never rose after the start pulse");
            timeout_count++;
        end
    endtask

    // Output stalled, input FIFO must eventually refuse data
    task automatic fill_until_stalled;
        int cycles;
        cycles = 0;
        while (in_ready && cycles < 400) begin
            drive_cycle(100, 0);
            cycles++;
        end
        if (in_ready) begin
            $display("Timeout: in_ready stayed high while the output was stalled");
            timeout_count++;
        end
    endtask

    task automatic drain_output;
        int cycles;
        cycles = 0;
        in_valid  = 1'b0;
        out_ready = 1'b1;
        while ((outstanding != 0 || out_valid) && cycles < 500) begin
            @(posedge ap_clk);
            #2;
            cycles++;
        end
        if (outstanding != 0 || out_valid) begin
            $display("Timeout: output did not drain, %0d packets still expected", outstanding);
            timeout_count++;
        end
    endtask

    initial begin
        areset_generator = 1'b1;
        start            = 1'b0;
        in_packet        = '0;
        in_valid         = 1'b0;
        out_ready        = 1'b0;
        final_check      = 1'b0;
        repeat (10) @(posedge ap_clk);
        #2;
        areset_generator = 1'b0;
        repeat (3) @(posedge ap_clk);
        #2;
        start = 1'b1;
        @(posedge ap_clk);
        #2;
        start = 1'b0;
        wait_for_busy();
        if (timeout_count == 0) begin
            repeat (400) drive_cycle(70, 60);
            drain_output();
            fill_until_stalled();
            repeat (20) drive_cycle(100, 0);
            drain_output();
        end
        final_check = 1'b1;
        @(posedge ap_clk);
        #2;
        final_check = 1'b0;
        $display("Closing counts: %0d checks, %0d errors, %0d timeouts",
                 check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule : fwd_gen_tb

//--- test/fwd_gen_checker.sv
// Forward generator reference model and checker

`timescale 1ns/10ps
`include "fwd_gen_config.svh"

module fwd_gen_checker
    import fwd_gen_pkg::*;
(
    input  logic                 ap_clk,
    input  logic                 areset_generator,
    input  logic                 cfg_req,
    input  logic                 cfg_ack,
    input  logic [`FWD_ID_W-1:0] cfg_forward_value,
    input  logic                 busy,
    input  mem_packet_t          in_packet,
    input  logic                 in_valid,
    input  logic                 in_ready,
    input  mem_packet_t          out_packet,
    input  logic                 out_valid,
    input  logic                 out_ready,
    input  logic                 final_check,
    output int                   error_count,
    output int                   check_count,
    output int                   outstanding
);

    mem_packet_t          accepted[$];
    logic [`FWD_ID_W-1:0] offset = '0;
    logic                 was_reset = 1'b0;
    logic                 busy_q = 1'b0;
    int                   handshakes = 0;

    // Ids at or below the offset end up as zero
    function automatic logic [`FWD_ID_W-1:0] expected_id(
        input logic [`FWD_ID_W-1:0] id,
        input logic [`FWD_ID_W-1:0] ofs
    );
        return (id > ofs) ? id - ofs : '0;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED time %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    always @(posedge ap_clk) begin : model
        mem_packet_t exp_pkt;
        int          left;
        if (areset_generator) begin
            accepted.delete();
            handshakes  = 0;
            error_count = 0;
            check_count = 0;
            outstanding = 0;
            was_reset   = 1'b1;
        end else begin
            if (was_reset) begin
                check_value("cfg_req after reset", 32'(cfg_req), 32'd0);
                check_value("busy after reset", 32'(busy), 32'd0);
                check_value("out_valid after reset", 32'(out_valid), 32'd0);
                check_value("in_ready after reset", 32'(in_ready), 32'd1);
            end
            was_reset = 1'b0;
            if (cfg_req && cfg_ack) begin
                handshakes++;
                offset = cfg_forward_value;
            end
            if (busy && !busy_q) begin
                check_value("handshakes before busy", handshakes, 32'd1);
            end
            busy_q = busy;

            // ------------------------------------------------------
            // Output compare against the accepted order
            // ------------------------------------------------------
            if (out_valid && out_ready) begin
                while (accepted.size() > 0 && expected_id(accepted[0].to_id, offset) == '0) begin
                    void'(accepted.pop_front());
                end
                if (accepted.size() == 0) begin
                    error_count++;
                    $display("Output transfer at time %0t with no packet expected", $time);
                end else begin
                    exp_pkt = accepted.pop_front();
                    check_value("out_packet.from_id", 32'(out_packet.from_id),
                                32'(expected_id(exp_pkt.from_id, offset)));
                    check_value("out_packet.to_id", 32'(out_packet.to_id),
                                32'(expected_id(exp_pkt.to_id, offset)));
                    check_value("out_packet.data", out_packet.data, exp_pkt.data);
                end
            end
            if (in_valid && in_ready) begin
                accepted.push_back(in_packet);
            end
            left = 0;
            foreach (accepted[i]) begin
                if (expected_id(accepted[i].to_id, offset) != '0) begin
                    left++;
                end
            end
            outstanding = left;
            if (final_check) begin
                check_value("cfg handshakes", handshakes, 32'd1);
                check_value("busy at end", 32'(busy), 32'd1);
                check_value("packets left", outstanding, 32'd0);
            end
        end
    end

endmodule : fwd_gen_checker

//--- test/fwd_gen_asserts.sv
// Handshake and FIFO flag assertions

`timescale 1ns/10ps

module fwd_gen_asserts
    import fwd_gen_pkg::*;
(
    input logic ap_clk,
    input logic areset_generator,
    input logic cfg_req,
    input logic cfg_ack,
    input logic busy,
    input logic in_full,
    input logic out_full,
    input logic out_prog_full
);

    // Request held until the source acknowledges
    req_held_until_ack: assert property (@(posedge ap_clk) disable iff (areset_generator)
        $fell(cfg_req) |-> $past(cfg_ack))
        else $error("cfg_req fell before cfg_ack rose");

    ack_held_while_req: assert property (@(posedge ap_clk) disable iff (areset_generator)
        $fell(cfg_ack) |-> !cfg_req)
        else $error("cfg_ack fell while cfg_req was high");

    // ----------------------------------------------------------
    // FIFO flags
    // ----------------------------------------------------------
    // Input side fills only while pops are held off
    in_full_only_when_held: assert property (@(posedge ap_clk) disable iff (areset_generator)
        $rose(in_full) |-> $past(out_prog_full || !busy))
        else $error("input FIFO filled up while pops were allowed");

    // Threshold margin covers the packet in flight
    out_never_full: assert property (@(posedge ap_clk) disable iff (areset_generator)
        !out_full)
        else $error("output FIFO filled up despite prog_full");

endmodule : fwd_gen_asserts

bind fwd_data_generator fwd_gen_asserts i_asserts (
    .ap_clk           (ap_clk),
    .areset_generator (areset_generator),
    .cfg_req          (cfg_req),
    .cfg_ack          (cfg_ack),
    .busy             (busy),
    .in_full          (in_full),
    .out_full         (i_out_fifo.full),
    .out_prog_full    (out_prog_full)
);

//--- hw/fwd_data_generator.sv
// Forward data generator top

`timescale 1ns/10ps
`include "fwd_gen_config.svh"

module fwd_data_generator
    import fwd_gen_pkg::*;
(
    input  logic                 ap_clk,
    input  logic                 areset_generator,
    input  logic                 start,
    input  logic                 cfg_ack,
    input  logic [`FWD_ID_W-1:0] cfg_forward_value,
    input  mem_packet_t          in_packet,
    input  logic                 in_valid,
    output logic                 in_ready,
    output mem_packet_t          out_packet,
    output logic                 out_valid,
    input  logic                 out_ready,
    output logic                 cfg_req,
    output logic                 busy
);

    logic                 run;
    logic [`FWD_ID_W-1:0] forward_value;
    mem_packet_t          in_head;
    mem_packet_t          rebased_packet;
    logic                 in_full;
    logic                 in_empty;
    logic                 in_pop;
    logic                 out_push;
    logic                 out_empty;
    logic                 out_prog_full;

    assign in_ready  = ~in_full;
    assign out_valid = ~out_empty;

    fwd_config_ctrl i_ctrl (
        .ap_clk            (ap_clk),
        .areset_generator  (areset_generator),
        .start             (start),
        .cfg_ack           (cfg_ack),
        .cfg_forward_value (cfg_forward_value),
        .cfg_req           (cfg_req),
        .run               (run),
        .busy              (busy),
        .forward_value     (forward_value)
    );

    fwd_sync_fifo i_in_fifo (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .push             (in_valid & in_ready),
        .din              (in_packet),
        .pop              (in_pop),
        .dout             (in_head),
        .full             (in_full),
        .empty            (in_empty),
        .prog_full        ()
    );

    fwd_rebase i_rebase (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .run              (run),
        .forward_value    (forward_value),
        .in_head          (in_head),
        .in_empty         (in_empty),
        .out_prog_full    (out_prog_full),
        .in_pop           (in_pop),
        .out_push         (out_push),
        .out_packet       (rebased_packet)
    );

    // Result queue toward the output port
    fwd_sync_fifo i_out_fifo (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .push             (out_push),
        .din              (rebased_packet),
        .pop              (out_valid & out_ready),
        .dout             (out_packet),
        .full             (),
        .empty            (out_empty),
        .prog_full        (out_prog_full)
    );

endmodule : fwd_data_generator

//--- hw/fwd_rebase.sv
// Forward id rebase and filter stage

`timescale 1ns/10ps
`include "fwd_gen_config.svh"

module fwd_rebase
    import fwd_gen_pkg::*;
(
    input  logic                 ap_clk,
    input  logic                 areset_generator,
    input  logic                 run,
    input  logic [`FWD_ID_W-1:0] forward_value,
    input  mem_packet_t          in_head,
    input  logic                 in_empty,
    input  logic                 out_prog_full,
    output logic                 in_pop,
    output logic                 out_push,
    output mem_packet_t          out_packet
);

    mem_packet_t rebased;

    // Subtract offset, clamp at zero
    function automatic logic [`FWD_ID_W-1:0] sat_sub(
        input logic [`FWD_ID_W-1:0] id,
        input logic [`FWD_ID_W-1:0] offset
    );
        return (id >= offset) ? id - offset : '0;
    endfunction

    // Hold off while the result queue is near full
    assign in_pop = run & ~in_empty & ~out_prog_full;

    always_comb begin
        rebased         = in_head;
        rebased.from_id = sat_sub(in_head.from_id, forward_value);
        rebased.to_id   = sat_sub(in_head.to_id, forward_value);
    end

    // ----------------------------------------------------------
    // Result register, push one cycle after pop
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            out_push <= 1'b0;
        end else begin
            // Zero destination means not for this lane
            out_push <= in_pop & (|rebased.to_id);
        end
    end

    always_ff @(posedge ap_clk) begin
        if (in_pop) begin
            out_packet <= rebased;
        end
    end

endmodule : fwd_rebase

//--- hw/fwd_config_ctrl.sv
// Run control and configuration fetch

`timescale 1ns/10ps
`include "fwd_gen_config.svh"

module fwd_config_ctrl
    import fwd_gen_pkg::*;
(
    input  logic                 ap_clk,
    input  logic                 areset_generator,
    input  logic                 start,
    input  logic                 cfg_ack,
    input  logic [`FWD_ID_W-1:0] cfg_forward_value,
    output logic                 cfg_req,
    output logic                 run,
    output logic                 busy,
    output logic [`FWD_ID_W-1:0] forward_value
);

    gen_state_t state;
    gen_state_t next_state;
    logic       run_q;

    // ----------------------------------------------------------
    // State machine
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (start) begin
                    next_state = CFG_REQ;
                end
            end
            CFG_REQ: begin
                if (cfg_ack) begin
                    next_state = CFG_RELEASE;
                end
            end
            CFG_RELEASE: begin
                // Source must drop ack before data flows
                if (!cfg_ack) begin
                    next_state = RUN;
                end
            end
            default: next_state = RUN;
        endcase
    end

    assign cfg_req = (state == CFG_REQ);

    // ----------------------------------------------------------
    // Offset capture and run flags
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            forward_value <= '1;
            run_q         <= 1'b0;
        end else begin
            if (cfg_req && cfg_ack) begin
                forward_value <= cfg_forward_value;
            end
            run_q <= (state == RUN);
        end
    end

    assign run  = run_q;
    assign busy = run_q;

endmodule : fwd_config_ctrl

//--- hw/fwd_sync_fifo.sv
// Synchronous packet FIFO

`timescale 1ns/10ps
`include "fwd_gen_config.svh"

module fwd_sync_fifo
    import fwd_gen_pkg::*;
(
    input  logic        ap_clk,
    input  logic        areset_generator,
    input  logic        push,
    input  mem_packet_t din,
    input  logic        pop,
    output mem_packet_t dout,
    output logic        full,
    output logic        empty,
    output logic        prog_full
);

    localparam int ADDR_W  = $clog2(`FWD_FIFO_DEPTH);
    localparam int COUNT_W = $clog2(`FWD_FIFO_DEPTH + 1);
    localparam logic [ADDR_W-1:0] LAST = ADDR_W'(`FWD_FIFO_DEPTH - 1);

    mem_packet_t        mem [`FWD_FIFO_DEPTH];
    logic [ADDR_W-1:0]  wr_ptr;
    logic [ADDR_W-1:0]  rd_ptr;
    logic [COUNT_W-1:0] count;
    logic               do_push;
    logic               do_pop;

    // Overflow and underflow requests are dropped
    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    always_ff @(posedge ap_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head entry shown without a read strobe
    assign dout      = mem[rd_ptr];
    assign full      = (count == COUNT_W'(`FWD_FIFO_DEPTH));
    assign empty     = (count == '0);
    assign prog_full = (count >= COUNT_W'(`FWD_PROG_THRESH));

endmodule : fwd_sync_fifo

//--- hw/fwd_gen_pkg.sv
// Forward generator shared types

`include "fwd_gen_config.svh"

package fwd_gen_pkg;

    // ----------------------------------------------------------
    // Memory packet
    // ----------------------------------------------------------
    // Route ids sit above the data field
    typedef struct packed {
        logic [`FWD_ID_W-1:0]   from_id;
        logic [`FWD_ID_W-1:0]   to_id;
        logic [`FWD_DATA_W-1:0] data;
    } mem_packet_t;

    // ----------------------------------------------------------
    // Run control states
    // ----------------------------------------------------------
    // CFG_REQ holds the request until ack
    // CFG_RELEASE waits for ack to drop
    typedef enum logic [1:0] {
        IDLE,
        CFG_REQ,
        CFG_RELEASE,
        RUN
    } gen_state_t;

endpackage : fwd_gen_pkg

//--- hw/fwd_gen_config.svh
// Forward generator widths and FIFO sizing

`ifndef FWD_GEN_CONFIG_SVH
`define FWD_GEN_CONFIG_SVH

// Route id and forward offset width
`define FWD_ID_W 8

// Packet data field width
`define FWD_DATA_W 32

// Entries per FIFO
`define FWD_FIFO_DEPTH 16

// Fill level where prog_full rises, leaves room for in-flight packets
`define FWD_PROG_THRESH 12

`endif
